// ==== source/prbs_defines.svh ====
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// datapath and lfsr width
`define PRBS_WIDTH        32
// error counter width, saturates at all ones
`define PRBS_ERR_BITS     16

// prbs31 taps on state bits 30 and 27, msb is the oldest bit
`define PRBS_DEFAULT_EQN  32'h4800_0000
// any nonzero value works as a start point
`define PRBS_DEFAULT_SEED 32'h1D5A_0F01

// apb byte offsets
`define PRBS_ADDR_CTRL    8'h00
`define PRBS_ADDR_EQN     8'h04
`define PRBS_ADDR_SEED    8'h08
`define PRBS_ADDR_STATE   8'h0C
`define PRBS_ADDR_ERRCNT  8'h10
`define PRBS_ADDR_STATUS  8'h14

// ctrl register bit positions
`define PRBS_CTRL_ENABLE  0
`define PRBS_CTRL_INVERT  1
// write one, self-clearing
`define PRBS_CTRL_INJECT  2
// write one, self-clearing
`define PRBS_CTRL_CLEAR   3

`endif

// ==== source/prbs_pkg.sv ====
`include "prbs_defines.svh"

package prbs_pkg;

    // register map, values are the apb byte offsets
    typedef enum logic [7:0] {
        REG_CTRL   = `PRBS_ADDR_CTRL,
        // feedback tap mask
        REG_EQN    = `PRBS_ADDR_EQN,
        // writing here also loads the generator
        REG_SEED   = `PRBS_ADDR_SEED,
        // read only, live generator state
        REG_STATE  = `PRBS_ADDR_STATE,
        // read only, checker mismatch count
        REG_ERRCNT = `PRBS_ADDR_ERRCNT,
        // read only, bit 0 is lock
        REG_STATUS = `PRBS_ADDR_STATUS
    } reg_addr_e;

    // checker fsm
    typedef enum logic {
        // collecting history, no comparisons yet
        CHK_FILL   = 1'b0,
        // predicting and counting mismatches
        CHK_LOCKED = 1'b1
    } chk_state_e;

endpackage

// ==== source/prbs_cfg_if.sv ====
`timescale 1ns/1ns
`include "prbs_defines.svh"

interface prbs_cfg_if;

    // static controls from the register block
    logic                      enable;
    logic                      invert;
    logic [`PRBS_WIDTH-1:0]    eqn;
    logic [`PRBS_WIDTH-1:0]    seed;

    // one-cycle strobes
    logic                      seed_load;
    logic                      inject;
    logic                      err_clear;

    // status back to the host
    logic [`PRBS_WIDTH-1:0]    state;
    logic                      locked;
    logic [`PRBS_ERR_BITS-1:0] err_count;

    // register block side
    modport regs (
        output enable, invert, eqn, seed, seed_load, inject, err_clear,
        input  state, locked, err_count
    );

    // transmit side
    modport gen (
        input  enable, invert, eqn, seed, seed_load, inject,
        output state
    );

    // receive side
    modport chk (
        input  enable, invert, eqn, err_clear,
        output locked, err_count
    );

endinterface

// ==== source/prbs_apb_regs.sv ====
`timescale 1ns/1ns
`include "prbs_defines.svh"

module prbs_apb_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [`PRBS_WIDTH-1:0] pwdata,
    output logic [`PRBS_WIDTH-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    prbs_cfg_if.regs               cfg
);

    // apb access phase and decoded register
    logic                access;
    logic                addr_hit;
    logic                wr_en;
    prbs_pkg::reg_addr_e reg_sel;

    // control registers
    logic                   enable_q;
    logic                   invert_q;
    logic [`PRBS_WIDTH-1:0] eqn_q;
    logic [`PRBS_WIDTH-1:0] seed_q;

    // strobes, one cycle after the write edge
    logic seed_load_q;
    logic inject_q;
    logic clear_q;

    // second cycle of a transfer
    assign access = psel && penable;

    // address decode into the register enum
    always_comb begin
        addr_hit = 1'b1;
        reg_sel  = prbs_pkg::REG_CTRL;
        case (paddr)
            `PRBS_ADDR_CTRL:   reg_sel = prbs_pkg::REG_CTRL;
            `PRBS_ADDR_EQN:    reg_sel = prbs_pkg::REG_EQN;
            `PRBS_ADDR_SEED:   reg_sel = prbs_pkg::REG_SEED;
            `PRBS_ADDR_STATE:  reg_sel = prbs_pkg::REG_STATE;
            `PRBS_ADDR_ERRCNT: reg_sel = prbs_pkg::REG_ERRCNT;
            `PRBS_ADDR_STATUS: reg_sel = prbs_pkg::REG_STATUS;
            // unmapped, flagged through pslverr
            default:           addr_hit = 1'b0;
        endcase
    end

    // writes land on the edge closing the access cycle
    assign wr_en = access && pwrite && addr_hit;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            invert_q <= 1'b0;
            eqn_q    <= `PRBS_DEFAULT_EQN;
            seed_q   <= `PRBS_DEFAULT_SEED;
        end else if (wr_en) begin
            case (reg_sel)
                prbs_pkg::REG_CTRL: begin
                    enable_q <= pwdata[`PRBS_CTRL_ENABLE];
                    invert_q <= pwdata[`PRBS_CTRL_INVERT];
                end
                prbs_pkg::REG_EQN: begin
                    eqn_q <= pwdata;
                end
                prbs_pkg::REG_SEED: begin
                    seed_q <= pwdata;
                end
                // state, errcnt and status are read only
                default: begin
                    enable_q <= enable_q;
                end
            endcase
        end
    end

    // strobes fall again on the next edge since
    // apb cannot write on two consecutive cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            seed_load_q <= 1'b0;
            inject_q    <= 1'b0;
            clear_q     <= 1'b0;
        end else begin
            seed_load_q <= wr_en && (reg_sel == prbs_pkg::REG_SEED);
            inject_q    <= wr_en && (reg_sel == prbs_pkg::REG_CTRL)
                           && pwdata[`PRBS_CTRL_INJECT];
            clear_q     <= wr_en && (reg_sel == prbs_pkg::REG_CTRL)
                           && pwdata[`PRBS_CTRL_CLEAR];
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        prdata = '0;
        if (addr_hit) begin
            case (reg_sel)
                prbs_pkg::REG_CTRL: begin
                    // strobe bits always read back zero
                    prdata[`PRBS_CTRL_ENABLE] = enable_q;
                    prdata[`PRBS_CTRL_INVERT] = invert_q;
                end
                prbs_pkg::REG_EQN:    prdata = eqn_q;
                prbs_pkg::REG_SEED:   prdata = seed_q;
                prbs_pkg::REG_STATE:  prdata = cfg.state;
                prbs_pkg::REG_ERRCNT: prdata = {{(`PRBS_WIDTH - `PRBS_ERR_BITS){1'b0}},
                                                cfg.err_count};
                // bit 0 is checker lock
                prbs_pkg::REG_STATUS: prdata = {{(`PRBS_WIDTH - 1){1'b0}}, cfg.locked};
                default:              prdata = '0;
            endcase
        end
    end

    // out to the datapath
    assign cfg.enable    = enable_q;
    assign cfg.invert    = invert_q;
    assign cfg.eqn       = eqn_q;
    assign cfg.seed      = seed_q;
    assign cfg.seed_load = seed_load_q;
    assign cfg.inject    = inject_q;
    assign cfg.err_clear = clear_q;

    // access phase only ever follows a setup phase of the same transfer
    a_apb_penable: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel && $past(psel)
    ) else $error("apb penable without a preceding psel");

endmodule

// ==== source/prbs_generator.sv ====
`timescale 1ns/1ns
`include "prbs_defines.svh"

module prbs_generator (
    input  logic    clk,
    input  logic    rst,
    prbs_cfg_if.gen cfg,
    output logic    tx_bit
);

    // fibonacci lfsr, msb oldest, new bit enters at the lsb
    logic [`PRBS_WIDTH-1:0] state;
    logic                   feedback;
    // stepping this cycle
    logic                   step;
    // inject seen while not stepping, waits for the next step
    logic                   inject_pend;
    logic                   flip;
    // msb alone with no tap on it would shift out to all zero
    logic                   lone_msb;

    // parity of the tapped bits
    assign feedback = ^(state & cfg.eqn);

    // seed load wins over stepping
    assign step = cfg.enable && !cfg.seed_load;

    // exactly one transmitted bit is flipped per inject
    assign flip = cfg.inject || inject_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= `PRBS_DEFAULT_SEED;
        end else if (cfg.seed_load) begin
            // applies even while disabled
            state <= cfg.seed;
        end else if (cfg.enable) begin
            state <= {state[`PRBS_WIDTH-2:0], feedback};
        end
    end

    // output lags the state that produced it by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_bit <= 1'b0;
        end else if (step) begin
            tx_bit <= state[`PRBS_WIDTH-1] ^ cfg.invert ^ flip;
        end
    end

    // remember an inject that arrives on a held cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            inject_pend <= 1'b0;
        end else if (step) begin
            inject_pend <= 1'b0;
        end else if (cfg.inject) begin
            inject_pend <= 1'b1;
        end
    end

    // host readback
    assign cfg.state = state;

    // the one degenerate case, msb set alone and eqn leaves it untapped
    assign lone_msb = (state == {1'b1, {(`PRBS_WIDTH - 1){1'b0}}})
                      && !cfg.eqn[`PRBS_WIDTH-1];

    // the lfsr never collapses into the all-zero lockup state
    a_no_lockup: assert property (
        @(posedge clk) disable iff (rst)
        step && (state != '0) && (cfg.eqn != '0) && !lone_msb |=> state != '0
    ) else $error("lfsr stepped into the all-zero state");

endmodule

// ==== source/prbs_checker.sv ====
`timescale 1ns/1ns
`include "prbs_defines.svh"

module prbs_checker (
    input  logic    clk,
    input  logic    rst,
    prbs_cfg_if.chk cfg,
    input  logic    rx_bit
);

    // enough bits to count one full history
    localparam int FILL_BITS = $clog2(`PRBS_WIDTH);
    localparam logic [FILL_BITS-1:0] FILL_LAST = FILL_BITS'(`PRBS_WIDTH - 1);

    // received bits, newest at the lsb
    logic [`PRBS_WIDTH-1:0]    hist;
    logic [FILL_BITS-1:0]      fill_cnt;
    prbs_pkg::chk_state_e      state;
    logic [`PRBS_ERR_BITS-1:0] err_cnt;

    // per-cycle compare
    logic sample;
    logic predict;
    logic mismatch;

    // undo the transmit inversion
    assign sample = rx_bit ^ cfg.invert;

    // same recurrence as the generator, history stands in for its state
    assign predict = ^(hist & cfg.eqn);

    // only meaningful once the history is full
    assign mismatch = (state == prbs_pkg::CHK_LOCKED) && (sample != predict);

    // history keeps running through a clear
    always_ff @(posedge clk) begin
        if (cfg.enable) begin
            hist <= {hist[`PRBS_WIDTH-2:0], sample};
        end
    end

    // lock fsm, fill for one full history then lock
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= prbs_pkg::CHK_FILL;
            fill_cnt <= '0;
        end else if (cfg.err_clear) begin
            // resync from scratch
            state    <= prbs_pkg::CHK_FILL;
            fill_cnt <= '0;
        end else if (cfg.enable && (state == prbs_pkg::CHK_FILL)) begin
            if (fill_cnt == FILL_LAST) begin
                state <= prbs_pkg::CHK_LOCKED;
            end
            // wraps back to zero on lock
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // saturating mismatch counter
    always_ff @(posedge clk) begin
        if (rst) begin
            err_cnt <= '0;
        end else if (cfg.err_clear) begin
            err_cnt <= '0;
        end else if (cfg.enable && mismatch && (err_cnt != '1)) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

    // status back to the registers
    assign cfg.locked    = (state == prbs_pkg::CHK_LOCKED);
    assign cfg.err_count = err_cnt;

    // filling never counts, only a clear may touch the count
    a_fill_quiet: assert property (
        @(posedge clk) disable iff (rst)
        (state == prbs_pkg::CHK_FILL) && !cfg.err_clear |=> $stable(err_cnt)
    ) else $error("error count moved while the checker was filling");

endmodule

// ==== source/prbs_top.sv ====
`timescale 1ns/1ns
`include "prbs_defines.svh"

module prbs_top (
    input  logic                   clk,
    input  logic                   rst,
    // apb slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [`PRBS_WIDTH-1:0] pwdata,
    output logic [`PRBS_WIDTH-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    // serial link
    output logic                   tx_bit,
    input  logic                   rx_bit
);

    // config and status shared by all three blocks
    prbs_cfg_if cfg ();

    // host register block
    prbs_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg)
    );

    // transmit lfsr
    prbs_generator u_gen (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .tx_bit (tx_bit)
    );

    // receive check and error count
    prbs_checker u_chk (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .rx_bit (rx_bit)
    );

endmodule

// ==== test/prbs_tests.svh ====
`ifndef PRBS_TESTS_SVH
`define PRBS_TESTS_SVH

task automatic test_reset_values();
    check_value("tx_bit", {31'b0, tx_bit}, 32'h0);
    read_expect(`PRBS_ADDR_CTRL, "ctrl", 32'h0);
    read_expect(`PRBS_ADDR_EQN, "eqn", `PRBS_DEFAULT_EQN);
    read_expect(`PRBS_ADDR_SEED, "seed", `PRBS_DEFAULT_SEED);
    read_expect(`PRBS_ADDR_STATE, "state", `PRBS_DEFAULT_SEED);
    read_expect(`PRBS_ADDR_ERRCNT, "errcnt", 32'h0);
    read_expect(`PRBS_ADDR_STATUS, "status", 32'h0);
endtask

task automatic test_seed_and_step();
    logic [31:0] model;
    apb_write(`PRBS_ADDR_EQN, TEST_EQN);
    // seed loads even while disabled
    apb_write(`PRBS_ADDR_SEED, TEST_SEED);
    read_expect(`PRBS_ADDR_STATE, "state after seed", TEST_SEED);
    apb_write(`PRBS_ADDR_CTRL, CTRL_EN);
    wait_cycles(STEP_RUN);
    apb_write(`PRBS_ADDR_CTRL, 32'h0);
    // steps on every edge after the enable write up to the disable edge
    model = TEST_SEED;
    repeat (STEP_RUN + 3) model = lfsr_step(model, TEST_EQN);
    read_expect(`PRBS_ADDR_STATE, "state after run", model);
endtask

task automatic test_tx_stream(input logic inv);
    logic [31:0] model;
    apb_write(`PRBS_ADDR_SEED, TEST_SEED);
    model = TEST_SEED;
    apb_write(`PRBS_ADDR_CTRL, CTRL_EN | (inv ? CTRL_INV : 32'h0));
    // tx_bit shows the msb of the state one step earlier
    for (int i = 0; i < 64; i++) begin
        @(posedge clk);
        #1;
        check_value($sformatf("tx_bit[%0d]", i), {31'b0, tx_bit}, {31'b0, model[31] ^ inv});
        model = lfsr_step(model, TEST_EQN);
    end
    apb_write(`PRBS_ADDR_CTRL, 32'h0);
endtask

task automatic test_checker_lock(input logic inv);
    logic [31:0] ctrl;
    ctrl = CTRL_EN | (inv ? CTRL_INV : 32'h0);
    apb_write(`PRBS_ADDR_CTRL, ctrl);
    // drop whatever the invert change disturbed
    apb_write(`PRBS_ADDR_CTRL, ctrl | CTRL_CLR);
    wait_cycles(100);
    read_expect(`PRBS_ADDR_STATUS, "status locked", 32'h1);
    read_expect(`PRBS_ADDR_ERRCNT, "errcnt clean", 32'h0);
endtask

task automatic test_inject_error();
    int per_flip;
    per_flip = 1 + count_taps(TEST_EQN);
    apb_write(`PRBS_ADDR_CTRL, CTRL_EN | CTRL_INV | CTRL_INJ);
    // flipped bit is mispredicted once and then once per tap it crosses
    wait_cycles(40);
    read_expect(`PRBS_ADDR_ERRCNT, "errcnt after inject", per_flip);
    // one bit corrupted on the receive side costs the same
    rx_flip = 1'b1;
    wait_cycles(1);
    rx_flip = 1'b0;
    wait_cycles(40);
    read_expect(`PRBS_ADDR_ERRCNT, "errcnt after rx flip", 2 * per_flip);
endtask

task automatic test_clear_and_unmapped();
    logic [31:0] data;
    logic        err;
    // disabled so the checker stays in fill
    apb_write(`PRBS_ADDR_CTRL, CTRL_CLR);
    read_expect(`PRBS_ADDR_ERRCNT, "errcnt after clear", 32'h0);
    read_expect(`PRBS_ADDR_STATUS, "status after clear", 32'h0);
    apb_read(8'h1C, data, err);
    check_value("pslverr unmapped", {31'b0, err}, 32'h1);
endtask

`endif

// ==== test/prbs_tb.sv ====
`timescale 1ns/1ns
`include "prbs_defines.svh"

module prbs_tb;

    // longest test path is about 600 cycles
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [31:0] TEST_EQN  = 32'h8020_0003;
    localparam logic [31:0] TEST_SEED = 32'hC3A5_1E77;
    localparam int STEP_RUN = 20;
    localparam logic [31:0] CTRL_EN  = 32'h1 << `PRBS_CTRL_ENABLE;
    localparam logic [31:0] CTRL_INV = 32'h1 << `PRBS_CTRL_INVERT;
    localparam logic [31:0] CTRL_INJ = 32'h1 << `PRBS_CTRL_INJECT;
    localparam logic [31:0] CTRL_CLR = 32'h1 << `PRBS_CTRL_CLEAR;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        tx_bit;
    logic        rx_bit;
    // flips the received bit while high
    logic        rx_flip;
    int          cycle_count = 0;

    prbs_top dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx_bit  (tx_bit),
        .rx_bit  (rx_bit)
    );

    // serial loopback
    assign rx_bit = tx_bit ^ rx_flip;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests never finished", cycle_count);
            $display("Something failed");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    // one lfsr step shifts left and feeds the tapped parity into the lsb
    function automatic logic [31:0] lfsr_step(input logic [31:0] st, input logic [31:0] eqn);
        return {st[30:0], ^(st & eqn)};
    endfunction

    function automatic int count_taps(input logic [31:0] eqn);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += eqn[i];
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // returns 1 ns after the last of n edges
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // write lands on the third edge after the call
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // prdata sampled mid access cycle
    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        check_value("pready", {31'b0, pready}, 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input string name,
                               input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value(name, data, expected);
        check_value({name, " pslverr"}, {31'b0, err}, 32'h0);
    endtask

    `include "prbs_tests.svh"

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rx_flip = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_values();
        test_seed_and_step();
        test_tx_stream(1'b0);
        test_tx_stream(1'b1);
        test_checker_lock(1'b0);
        test_checker_lock(1'b1);
        test_inject_error();
        test_clear_and_unmapped();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
+incdir+test
source/prbs_pkg.sv
source/prbs_cfg_if.sv
source/prbs_apb_regs.sv
source/prbs_generator.sv
source/prbs_checker.sv
source/prbs_top.sv
test/prbs_tb.sv

// ==== Bender.yml ====
package:
  name: prbs_link_tester

sources:
  - include_dirs:
      - source
    files:
      - source/prbs_pkg.sv
      - source/prbs_cfg_if.sv
      - source/prbs_apb_regs.sv
      - source/prbs_generator.sv
      - source/prbs_checker.sv
      - source/prbs_top.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/prbs_tb.sv
